//--- verilog/sib_pkg.sv
/*
  SampleInBall shared definitions
  Controller FSM states, coefficient codes, memory geometry and the
  structs that carry swap requests and memory port requests between
  the sampling stage, the shuffler and the coefficient memory.
*/
package sib_pkg;

  // Polynomial and stream geometry
  localparam int SIB_NUM_COEFF  = 256;
  localparam int SIB_SAMPLE_W   = 8;
  localparam int SIB_MEM_ADDR_W = 6;
  localparam int SIB_COEF_W     = 2;

  // Coefficient codes, two's complement style
  localparam logic [SIB_COEF_W-1:0] SIB_COEF_ZERO = 2'b00;
  localparam logic [SIB_COEF_W-1:0] SIB_COEF_POS  = 2'b01;
  localparam logic [SIB_COEF_W-1:0] SIB_COEF_NEG  = 2'b11;

  typedef enum logic [1:0] {
    SIB_IDLE        = 2'd0,
    SIB_SIGN_BUFFER = 2'd1,
    SIB_ACTIVE      = 2'd2,
    SIB_DONE        = 2'd3
  } sib_fsm_state_e;

  // Coefficient k lives in word k/4, lane k%4
  typedef logic [3:0][SIB_COEF_W-1:0] sib_coef_word_t;

  // One swap of c[i] and c[j], with the sign for the new c[j]
  typedef struct packed {
    logic [SIB_SAMPLE_W-1:0] index_i;
    logic [SIB_SAMPLE_W-1:0] index_j;
    logic                    sign;
  } sib_swap_t;

  // One memory port request
  typedef struct packed {
    logic                      cs;
    logic                      we;
    logic [SIB_MEM_ADDR_W-1:0] addr;
    sib_coef_word_t            wrdata;
  } sib_mem_req_t;

endpackage

//--- verilog/sample_in_ball_ctrl.sv
/*
  SampleInBall sampling stage
  Collects the sign bits from the first two stream beats, then scans
  candidate bytes lane by lane against the running index i. The first
  acceptable byte becomes j and is offered to the shuffler together
  with i and the current sign bit. Ends the run after i reaches 255.
*/
`timescale 1ns/1ps

module sample_in_ball_ctrl #(
  parameter int SIB_TAU          = 60,
  parameter int SIB_NUM_SAMPLERS = 4
) (
  input  logic                                                 clk,
  input  logic                                                 rst_b,
  input  logic                                                 zeroize_i,
  input  logic                                                 data_valid_i,
  output logic                                                 data_hold_o,
  input  logic [SIB_NUM_SAMPLERS-1:0][sib_pkg::SIB_SAMPLE_W-1:0] data_i,
  output logic                                                 sib_done_o,
  output logic                                                 swap_valid_o,
  output sib_pkg::sib_swap_t                                   swap_o,
  input  logic                                                 swap_hold_i
);

  localparam int BEAT_W = SIB_NUM_SAMPLERS * sib_pkg::SIB_SAMPLE_W;
  localparam int LANE_W = (SIB_NUM_SAMPLERS > 1) ? $clog2(SIB_NUM_SAMPLERS) : 1;
  localparam logic [sib_pkg::SIB_SAMPLE_W-1:0] REJ_INIT =
    sib_pkg::SIB_SAMPLE_W'(sib_pkg::SIB_NUM_COEFF - SIB_TAU);

  sib_pkg::sib_fsm_state_e fsm_ps;
  sib_pkg::sib_fsm_state_e fsm_ns;

  logic [SIB_TAU-1:0]                sign_buffer;
  logic [SIB_TAU-1:0]                sign_buffer_d;
  logic [2*BEAT_W-1:0]               sign_buffer_nxt;
  logic                              sign_fill;
  logic                              sign_upper;
  logic [sib_pkg::SIB_SAMPLE_W-1:0]  rej_value;
  logic [SIB_NUM_SAMPLERS-1:0]       sampler_mask;
  logic [SIB_NUM_SAMPLERS-1:0]       sampler_mask_d;
  logic [SIB_NUM_SAMPLERS-1:0]       sampler_valid;
  logic                              index_found;
  logic [LANE_W-1:0]                 valid_index;
  logic                              sampler_hold;
  logic                              in_active;
  logic                              swap_accept;
  logic                              beat_consumed;
  logic                              last_sample;

  always_comb begin
    fsm_ns = fsm_ps;
    unique case (fsm_ps)
      sib_pkg::SIB_IDLE: begin
        if (data_valid_i) begin
          fsm_ns = sib_pkg::SIB_SIGN_BUFFER;
        end
      end
      sib_pkg::SIB_SIGN_BUFFER: begin
        if (data_valid_i) begin
          fsm_ns = sib_pkg::SIB_ACTIVE;
        end
      end
      sib_pkg::SIB_ACTIVE: begin
        if (last_sample) begin
          fsm_ns = sib_pkg::SIB_DONE;
        end
      end
      default: begin
        fsm_ns = sib_pkg::SIB_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      fsm_ps <= sib_pkg::SIB_IDLE;
    end else if (zeroize_i) begin
      fsm_ps <= sib_pkg::SIB_IDLE;
    end else begin
      fsm_ps <= fsm_ns;
    end
  end

  // Per-lane rejection, byte must not exceed i
  for (genvar g = 0; g < SIB_NUM_SAMPLERS; g++) begin : g_lane_cmp
    assign sampler_valid[g] = data_valid_i & sampler_mask[g] & (data_i[g] <= rej_value);
  end

  // First unmasked hit from lane 0 up; lanes up to the hit get masked
  always_comb begin
    index_found    = 1'b0;
    valid_index    = '0;
    sampler_mask_d = sampler_mask;
    for (int k = 0; k < SIB_NUM_SAMPLERS; k++) begin
      if (!index_found) begin
        sampler_mask_d[k] = 1'b0;
        if (sampler_valid[k]) begin
          index_found = 1'b1;
          valid_index = LANE_W'(k);
        end
      end
    end
  end

  assign in_active     = (fsm_ps == sib_pkg::SIB_ACTIVE);
  assign sampler_hold  = index_found & (valid_index != LANE_W'(SIB_NUM_SAMPLERS - 1));
  assign swap_valid_o  = in_active & index_found;
  assign swap_accept   = swap_valid_o & ~swap_hold_i;
  assign data_hold_o   = swap_valid_o & (sampler_hold | swap_hold_i);
  assign beat_consumed = in_active & data_valid_i & ~data_hold_o;
  assign last_sample   = swap_accept & (&rej_value);
  assign sib_done_o    = (fsm_ps == sib_pkg::SIB_DONE);

  assign swap_o.index_i = rej_value;
  assign swap_o.index_j = data_i[valid_index];
  assign swap_o.sign    = sign_buffer[0];

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      sampler_mask <= '1;
    end else if (zeroize_i || sib_done_o || beat_consumed) begin
      sampler_mask <= '1;
    end else if (swap_accept && sampler_hold) begin
      sampler_mask <= sampler_mask_d;
    end
  end

  // First beat fills the low sign bits, second beat the upper ones
  assign sign_fill  = data_valid_i & ((fsm_ps == sib_pkg::SIB_IDLE) | sign_upper);
  assign sign_upper = (fsm_ps == sib_pkg::SIB_SIGN_BUFFER);
  assign sign_buffer_nxt = sign_upper ? {data_i, {BEAT_W{1'b0}}} : {{BEAT_W{1'b0}}, data_i};
  assign sign_buffer_d   = (sign_upper ? sign_buffer : '0) | sign_buffer_nxt[SIB_TAU-1:0];

  // One sign bit is used up per accepted swap
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      sign_buffer <= '0;
    end else if (zeroize_i) begin
      sign_buffer <= '0;
    end else if (sign_fill) begin
      sign_buffer <= sign_buffer_d;
    end else if (swap_accept) begin
      sign_buffer <= sign_buffer >> 1;
    end
  end

  // Index i runs from 256-TAU to 255
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      rej_value <= REJ_INIT;
    end else if (zeroize_i || sib_done_o) begin
      rej_value <= REJ_INIT;
    end else if (swap_accept) begin
      rej_value <= rej_value + 1'b1;
    end
  end

endmodule

//--- verilog/sample_in_ball_shuffler.sv
/*
  SampleInBall shuffler
  Takes one swap request, reads the words holding c[i] and c[j], then
  writes c[i] with the old c[j] and c[j] with the signed unit code.
  Updates in a shared word are merged into a single write. Accepts at
  most one swap every two cycles.
*/
`timescale 1ns/1ps

module sample_in_ball_shuffler (
  input  logic                    clk,
  input  logic                    rst_b,
  input  logic                    zeroize_i,
  input  logic                    swap_valid_i,
  input  sib_pkg::sib_swap_t      swap_i,
  output logic                    swap_hold_o,
  output sib_pkg::sib_mem_req_t   req0_o,
  output sib_pkg::sib_mem_req_t   req1_o,
  input  sib_pkg::sib_coef_word_t rddata0_i,
  input  sib_pkg::sib_coef_word_t rddata1_i
);

  localparam int SW = sib_pkg::SIB_SAMPLE_W;

  logic                                swap_accept;
  logic                                wr_phase;
  sib_pkg::sib_swap_t                  swap_q;
  logic [1:0]                          lane_i;
  logic [1:0]                          lane_j;
  logic [sib_pkg::SIB_MEM_ADDR_W-1:0]  addr_i;
  logic [sib_pkg::SIB_MEM_ADDR_W-1:0]  addr_j;
  logic                                same_word;
  logic [sib_pkg::SIB_COEF_W-1:0]      old_cj;
  logic [sib_pkg::SIB_COEF_W-1:0]      sign_code;
  sib_pkg::sib_coef_word_t             word_i;
  sib_pkg::sib_coef_word_t             word_j;
  sib_pkg::sib_coef_word_t             merged;

  // Hold is the write cycle itself
  assign swap_hold_o = wr_phase;
  assign swap_accept = swap_valid_i & ~wr_phase & ~zeroize_i;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      wr_phase <= 1'b0;
    end else if (zeroize_i) begin
      wr_phase <= 1'b0;
    end else begin
      wr_phase <= swap_accept;
    end
  end

  always_ff @(posedge clk) begin
    if (swap_accept) begin
      swap_q <= swap_i;
    end
  end

  assign lane_i    = swap_q.index_i[1:0];
  assign lane_j    = swap_q.index_j[1:0];
  assign addr_i    = swap_q.index_i[SW-1:2];
  assign addr_j    = swap_q.index_j[SW-1:2];
  assign same_word = (addr_i == addr_j);

  // Build write words from the data returned for the reads
  always_comb begin
    old_cj    = rddata1_i[lane_j];
    sign_code = swap_q.sign ? sib_pkg::SIB_COEF_NEG : sib_pkg::SIB_COEF_POS;

    word_i         = rddata0_i;
    word_i[lane_i] = old_cj;
    word_j         = rddata1_i;
    word_j[lane_j] = sign_code;

    // c[j] update applied last so it wins when i equals j
    merged         = word_i;
    merged[lane_j] = sign_code;
  end

  always_comb begin
    req0_o = '0;
    req1_o = '0;
    if (wr_phase) begin
      req0_o.cs     = 1'b1;
      req0_o.we     = 1'b1;
      req0_o.addr   = addr_i;
      req0_o.wrdata = same_word ? merged : word_i;
      req1_o.cs     = ~same_word;
      req1_o.we     = ~same_word;
      req1_o.addr   = addr_j;
      req1_o.wrdata = word_j;
    end else if (swap_accept) begin
      // Read both words in the acceptance cycle
      req0_o.cs   = 1'b1;
      req0_o.addr = swap_i.index_i[SW-1:2];
      req1_o.cs   = 1'b1;
      req1_o.addr = swap_i.index_j[SW-1:2];
    end
  end

endmodule

//--- verilog/sib_coef_mem.sv
/*
  SampleInBall coefficient memory
  64 words of four 2-bit coefficient codes. Two request ports serve
  the shuffler, a third read-only port serves the host. All reads are
  registered. Zeroize wipes the whole array in one cycle.
*/
`timescale 1ns/1ps

module sib_coef_mem (
  input  logic                               clk,
  input  logic                               rst_b,
  input  logic                               zeroize_i,
  input  sib_pkg::sib_mem_req_t              req0_i,
  input  sib_pkg::sib_mem_req_t              req1_i,
  output sib_pkg::sib_coef_word_t            rddata0_o,
  output sib_pkg::sib_coef_word_t            rddata1_o,
  input  logic [sib_pkg::SIB_MEM_ADDR_W-1:0] rd_addr_i,
  output sib_pkg::sib_coef_word_t            rd_data_o
);

  localparam int DEPTH = 2 ** sib_pkg::SIB_MEM_ADDR_W;
  localparam sib_pkg::sib_coef_word_t ZERO_WORD = {4{sib_pkg::SIB_COEF_ZERO}};

  sib_pkg::sib_coef_word_t mem [DEPTH];

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      for (int w = 0; w < DEPTH; w++) begin
        mem[w] <= ZERO_WORD;
      end
    end else if (zeroize_i) begin
      for (int w = 0; w < DEPTH; w++) begin
        mem[w] <= ZERO_WORD;
      end
    end else begin
      if (req0_i.cs && req0_i.we) begin
        mem[req0_i.addr] <= req0_i.wrdata;
      end
      if (req1_i.cs && req1_i.we) begin
        mem[req1_i.addr] <= req1_i.wrdata;
      end
    end
  end

  // Registered read ports
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      rddata0_o <= ZERO_WORD;
      rddata1_o <= ZERO_WORD;
      rd_data_o <= ZERO_WORD;
    end else if (zeroize_i) begin
      rddata0_o <= ZERO_WORD;
      rddata1_o <= ZERO_WORD;
      rd_data_o <= ZERO_WORD;
    end else begin
      if (req0_i.cs && !req0_i.we) begin
        rddata0_o <= mem[req0_i.addr];
      end
      if (req1_i.cs && !req1_i.we) begin
        rddata1_o <= mem[req1_i.addr];
      end
      rd_data_o <= mem[rd_addr_i];
    end
  end

endmodule

//--- verilog/sib_top.sv
/*
  SampleInBall top level
  Sampling stage feeding the shuffler, with the coefficient memory
  behind it and a host read port for the finished polynomial.
*/
`timescale 1ns/1ps

module sib_top #(
  parameter int SIB_TAU          = 60,
  parameter int SIB_NUM_SAMPLERS = 4
) (
  input  logic                                                   clk,
  input  logic                                                   rst_b,
  input  logic                                                   zeroize_i,
  input  logic                                                   data_valid_i,
  output logic                                                   data_hold_o,
  input  logic [SIB_NUM_SAMPLERS-1:0][sib_pkg::SIB_SAMPLE_W-1:0] data_i,
  output logic                                                   sib_done_o,
  input  logic [sib_pkg::SIB_MEM_ADDR_W-1:0]                     rd_addr_i,
  output sib_pkg::sib_coef_word_t                                rd_data_o
);

  logic                    swap_valid;
  sib_pkg::sib_swap_t      swap;
  logic                    swap_hold;
  sib_pkg::sib_mem_req_t   req0;
  sib_pkg::sib_mem_req_t   req1;
  sib_pkg::sib_coef_word_t rddata0;
  sib_pkg::sib_coef_word_t rddata1;

  sample_in_ball_ctrl #(
    .SIB_TAU          (SIB_TAU),
    .SIB_NUM_SAMPLERS (SIB_NUM_SAMPLERS)
  ) u_ctrl (
    .clk          (clk),
    .rst_b        (rst_b),
    .zeroize_i    (zeroize_i),
    .data_valid_i (data_valid_i),
    .data_hold_o  (data_hold_o),
    .data_i       (data_i),
    .sib_done_o   (sib_done_o),
    .swap_valid_o (swap_valid),
    .swap_o       (swap),
    .swap_hold_i  (swap_hold)
  );

  sample_in_ball_shuffler u_shuffler (
    .clk          (clk),
    .rst_b        (rst_b),
    .zeroize_i    (zeroize_i),
    .swap_valid_i (swap_valid),
    .swap_i       (swap),
    .swap_hold_o  (swap_hold),
    .req0_o       (req0),
    .req1_o       (req1),
    .rddata0_i    (rddata0),
    .rddata1_i    (rddata1)
  );

  sib_coef_mem u_mem (
    .clk       (clk),
    .rst_b     (rst_b),
    .zeroize_i (zeroize_i),
    .req0_i    (req0),
    .req1_i    (req1),
    .rddata0_o (rddata0),
    .rddata1_o (rddata1),
    .rd_addr_i (rd_addr_i),
    .rd_data_o (rd_data_o)
  );

endmodule

//--- sim/sib_assert.sv
/*
  SampleInBall protocol checks
  Concurrent assertions on the shuffler handshake, the memory port
  read/write sequence, the done pulse and the stream hold rule.
*/
`timescale 1ns/1ps

module sib_assert #(
  parameter int BEAT_W = 32
) (
  input logic                  clk,
  input logic                  rst_b,
  input logic                  swap_hold_i,
  input sib_pkg::sib_mem_req_t req0_i,
  input logic                  sib_done_i,
  input logic                  data_valid_i,
  input logic                  data_hold_i,
  input logic [BEAT_W-1:0]     data_i
);

  // Shuffler takes a new swap at least every other cycle
  hold_single: assert property (@(posedge clk) disable iff (!rst_b)
    swap_hold_i |=> !swap_hold_i)
    else $error("swap_hold stayed high for two cycles");

  // Read on port 0 is always followed by the write-back
  read_then_write: assert property (@(posedge clk) disable iff (!rst_b)
    (req0_i.cs && !req0_i.we) |=> (req0_i.cs && req0_i.we))
    else $error("no write one cycle after a shuffler read");

  done_single: assert property (@(posedge clk) disable iff (!rst_b)
    sib_done_i |=> !sib_done_i)
    else $error("sib_done_o high for two cycles");

  data_held: assert property (@(posedge clk) disable iff (!rst_b)
    (data_valid_i && data_hold_i) |=> $stable(data_i))
    else $error("data_i changed while held");

endmodule

bind sib_top sib_assert #(
  .BEAT_W (SIB_NUM_SAMPLERS * sib_pkg::SIB_SAMPLE_W)
) u_assert (
  .clk          (clk),
  .rst_b        (rst_b),
  .swap_hold_i  (swap_hold),
  .req0_i       (req0),
  .sib_done_i   (sib_done_o),
  .data_valid_i (data_valid_i),
  .data_hold_i  (data_hold_o),
  .data_i       (data_i)
);

//--- sim/sib_tb.sv
/*
  SampleInBall testbench
  Directed vector from the pattern file, then random streams checked
  against a behavioral model: rejection heavy, collisions, gaps and
  a zeroize in the middle of a run. Readback goes through the host port.
*/
`timescale 1ns/1ps

module sib_tb;

  localparam int SIB_TAU   = 60;
  localparam int DIR_BEATS = 27;
  localparam int MAX_WAIT  = 5000;

  logic        clk;
  logic        rst_b;
  logic        zeroize_i;
  logic        data_valid_i;
  logic        data_hold_o;
  logic [31:0] data_i;
  logic        sib_done_o;
  logic [5:0]  rd_addr_i;
  logic [7:0]  rd_data_o;

  logic [31:0] pat_mem [0:DIR_BEATS+63];
  logic [31:0] beats_q [$];
  logic [7:0]  exp_words [64];
  int          model_beats;
  int          done_count;
  int          nonzero_cnt;
  int          bad_codes;

  sib_top #(
    .SIB_TAU (SIB_TAU)
  ) u_dut (
    .clk          (clk),
    .rst_b        (rst_b),
    .zeroize_i    (zeroize_i),
    .data_valid_i (data_valid_i),
    .data_hold_o  (data_hold_o),
    .data_i       (data_i),
    .sib_done_o   (sib_done_o),
    .rd_addr_i    (rd_addr_i),
    .rd_data_o    (rd_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Count done pulses away from the rising edge
  initial done_count = 0;
  always @(negedge clk) begin
    if (rst_b && sib_done_o) begin
      done_count++;
    end
  end

  task automatic value_error(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic abort_run(input string msg);
    $display("Run aborted: %s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped on error");
  endtask

  function automatic logic [1:0] coef_code(input int c);
    if (c < 0) begin
      return 2'b11;
    end
    return (c > 0) ? 2'b01 : 2'b00;
  endfunction

  // Reference SampleInBall on beats_q, gives exp_words and model_beats
  task automatic model_run();
    int          c [256];
    logic [63:0] sign;
    int          i;
    int          n;
    logic [7:0]  byte_v;
    for (int k = 0; k < 256; k++) begin
      c[k] = 0;
    end
    sign        = {beats_q[1], beats_q[0]};
    i           = 256 - SIB_TAU;
    n           = 0;
    model_beats = 0;
    for (int b = 2; b < beats_q.size() && model_beats == 0; b++) begin
      for (int l = 0; l < 4 && model_beats == 0; l++) begin
        byte_v = beats_q[b][8*l +: 8];
        if (int'(byte_v) <= i) begin
          c[i]              = c[int'(byte_v)];
          c[int'(byte_v)]   = sign[n] ? -1 : 1;
          n++;
          i++;
          if (i == 256) begin
            model_beats = b + 1;
          end
        end
      end
    end
    if (model_beats == 0) begin
      abort_run("stream too short for the model to finish");
    end
    for (int w = 0; w < 64; w++) begin
      for (int l = 0; l < 4; l++) begin
        exp_words[w][2*l +: 2] = coef_code(c[4*w+l]);
      end
    end
  endtask

  // Mode 0 uniform bytes, mode 1 mostly above i
  task automatic gen_stream(input int mode, input int nbeats);
    logic [31:0] beat;
    beats_q.delete();
    beats_q.push_back($urandom);
    beats_q.push_back($urandom);
    for (int b = 0; b < nbeats; b++) begin
      for (int l = 0; l < 4; l++) begin
        beat[8*l +: 8] = (mode == 1) ? 8'(150 + $urandom % 106) : 8'($urandom % 256);
      end
      beats_q.push_back(beat);
    end
  endtask

  // Every byte accepted, with j equal to i or in the same word
  task automatic gen_collide();
    logic [7:0] bytes [$];
    logic [7:0] jv;
    logic [31:0] beat;
    beats_q.delete();
    beats_q.push_back($urandom);
    beats_q.push_back($urandom);
    for (int i = 256 - SIB_TAU; i < 256; i++) begin
      if ($urandom % 2 == 1) begin
        jv = 8'(i);
      end else begin
        jv = 8'((i & 'hfc) + ($urandom % ((i & 3) + 1)));
      end
      bytes.push_back(jv);
    end
    while (bytes.size() % 4 != 0) begin
      bytes.push_back(8'hff);
    end
    for (int b = 0; b < bytes.size(); b += 4) begin
      beat = {bytes[b+3], bytes[b+2], bytes[b+1], bytes[b]};
      beats_q.push_back(beat);
    end
  endtask

  task automatic drive_beats(input int count, input int gap_max);
    int   cycles;
    logic held;
    for (int b = 0; b < count; b++) begin
      data_valid_i = 1'b1;
      data_i       = beats_q[b];
      cycles       = 0;
      held         = 1'b1;
      while (held) begin
        @(negedge clk);
        held = data_hold_o;
        @(posedge clk);
        #1;
        cycles++;
        if (cycles > MAX_WAIT) begin
          abort_run("beat held by the DUT for too long");
        end
      end
      if (gap_max > 0) begin
        data_valid_i = 1'b0;
        repeat (1 + $urandom % gap_max) begin
          @(posedge clk);
          #1;
        end
      end
    end
    data_valid_i = 1'b0;
  endtask

  task automatic pulse_zeroize();
    zeroize_i = 1'b1;
    @(posedge clk);
    #1;
    zeroize_i = 1'b0;
  endtask

  task automatic wait_done(input int start);
    int cycles;
    cycles = 0;
    while (done_count == start) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > MAX_WAIT) begin
        abort_run("no done pulse within 5000 cycles");
      end
    end
    repeat (4) begin
      @(posedge clk);
      #1;
    end
    assert (done_count == start + 1)
      else abort_run("done pulsed more than once in one run");
  endtask

  task automatic check_readback(input logic check_count);
    logic [7:0] got;
    nonzero_cnt = 0;
    bad_codes   = 0;
    for (int w = 0; w < 64; w++) begin
      rd_addr_i = 6'(w);
      @(posedge clk);
      @(negedge clk);
      got = rd_data_o;
      @(posedge clk);
      #1;
      assert (got == exp_words[w])
        else value_error($sformatf("word %0d read 0x%02h, expected 0x%02h",
                                   w, got, exp_words[w]));
      for (int l = 0; l < 4; l++) begin
        nonzero_cnt += (got[2*l +: 2] != 2'b00) ? 1 : 0;
        bad_codes   += (got[2*l +: 2] == 2'b10) ? 1 : 0;
      end
    end
    if (check_count) begin
      assert (nonzero_cnt == SIB_TAU && bad_codes == 0)
        else value_error($sformatf("%0d nonzero coefficients, %0d with code 10",
                                   nonzero_cnt, bad_codes));
    end
  endtask

  task automatic full_run(input int gap_max, input logic clear_first);
    int start;
    model_run();
    if (clear_first) begin
      pulse_zeroize();
    end
    start = done_count;
    drive_beats(model_beats, gap_max);
    wait_done(start);
    check_readback(1'b1);
  endtask

  initial begin
    int start;
    void'($urandom(32'h40020f95));
    rst_b        = 1'b0;
    zeroize_i    = 1'b0;
    data_valid_i = 1'b0;
    data_i       = '0;
    rd_addr_i    = '0;
    $readmemh("sim/sib_patterns.hex", pat_mem);
    repeat (4) @(posedge clk);
    #1;
    rst_b = 1'b1;
    @(posedge clk);
    #1;

    // Directed vector, expected words straight from the file
    beats_q.delete();
    for (int b = 0; b < DIR_BEATS; b++) begin
      beats_q.push_back(pat_mem[b]);
    end
    for (int w = 0; w < 64; w++) begin
      exp_words[w] = pat_mem[DIR_BEATS+w][7:0];
    end
    start = done_count;
    drive_beats(DIR_BEATS, 0);
    wait_done(start);
    check_readback(1'b1);

    gen_stream(1, 80);
    full_run(0, 1'b1);
    gen_collide();
    full_run(0, 1'b1);
    for (int r = 0; r < 3; r++) begin
      gen_stream(0, 60);
      full_run(3, 1'b1);
    end

    // Zeroize part way through a run
    gen_stream(0, 60);
    pulse_zeroize();
    start = done_count;
    drive_beats(10, 2);
    pulse_zeroize();
    for (int k = 0; k < 300; k++) begin
      @(posedge clk);
      #1;
      assert (done_count == start)
        else abort_run("done pulse after zeroize");
    end
    for (int w = 0; w < 64; w++) begin
      exp_words[w] = 8'h00;
    end
    check_readback(1'b0);

    // Next run starts from the state the zeroize left behind
    gen_stream(0, 60);
    full_run(2, 1'b0);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- build.f
verilog/sib_pkg.sv
verilog/sample_in_ball_ctrl.sv
verilog/sample_in_ball_shuffler.sv
verilog/sib_coef_mem.sv
verilog/sib_top.sv
sim/sib_assert.sv
sim/sib_tb.sv

//--- run.sh
#!/bin/sh
# Build the SampleInBall testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module sib_tb \
  -f build.f -o sib_sim \
  && ./obj_dir/sib_sim | grep "TESTBENCH PASSED" \
  || { echo "simulation did not pass"; exit 1; }

//--- sim/sib_patterns.hex
// Entries 0..26: stream beats, lane 0 in the low byte (2 sign beats, then candidates)
// Entries 27..90: expected coefficient memory words 0..63
FFFFFFFF 00000000
F001F000 F003F002 F005F004 F007F006 F009F008
F00BF00A F00DF00C F00FF00E F011F010 F013F012
F015F014 F017F016 F019F018 F01BF01A F01DF01C
F01FF01E F021F020 F023F022 F025F024 F027F026
2B2A2928 2F2E2D2C 33323130 37363534 3B3A3938
FF FF FF FF FF FF FF FF
55 55 55 55 55 55 55 00
00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00
